//--- rtl/csr_cfg.svh
// *********************************************************************
// configuration macros for the machine-mode CSR subsystem
//   register and bus data width
//   alignment of the trap vector base and of mepc
//   CLINT timer register offsets on the Wishbone port
// *********************************************************************
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// width of every CSR and of the timer registers
`define CSR_XLEN 64

// low bits of mtvec and mepc that read as zero
// mtvec mode field is fixed at direct mode
`define CSR_MTVEC_ALIGN 2

// wishbone address width of the timer slave
`define CSR_TMR_ADR_W 4

// byte offset of mtimecmp
`define CSR_TMR_CMP_OFS 4'h0

// byte offset of mtime
`define CSR_TMR_TIME_OFS 4'h8

`endif

//--- rtl/csr_pkg.sv
// *********************************************************************
// CSR access types
//   machine CSR address map
//   CSR instruction opcodes
//   request bundle from the core
// *********************************************************************
`include "csr_cfg.svh"

package csr_pkg;

    // machine-mode CSRs implemented in this subsystem
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MIP      = 12'h344,
        CSR_MCYCLE   = 12'hB00
    } csr_addr_e;

    // encodings follow funct3[1:0] of the csrr* instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // one CSR access, issued by the core only when not stalled
    typedef struct packed {
        logic                 valid;
        csr_op_e              op;
        logic [11:0]          addr;
        logic [`CSR_XLEN-1:0] src;
    } csr_req_t;

endpackage

//--- rtl/trap_pkg.sv
// *********************************************************************
// trap and commit types
//   mcause values
//   commit-time events from the core
//   trap event into the CSR file and pc redirect to the core
// *********************************************************************
`include "csr_cfg.svh"

package trap_pkg;

    // bit XLEN-1 marks an interrupt
    typedef enum logic [`CSR_XLEN-1:0] {
        CAUSE_ECALL_M = {{(`CSR_XLEN-4){1'b0}}, 4'd11},
        CAUSE_M_TIMER = {1'b1, {(`CSR_XLEN-4){1'b0}}, 3'd7}
    } trap_cause_e;

    typedef struct packed {
        logic                 ecall;
        logic                 mret;
        logic [`CSR_XLEN-1:0] pc;
    } commit_evt_t;

    typedef struct packed {
        logic                 take;
        logic                 ret;
        trap_cause_e          cause;
        logic [`CSR_XLEN-1:0] epc;
    } trap_evt_t;

    typedef struct packed {
        logic                 valid;
        logic [`CSR_XLEN-1:0] target;
    } redirect_t;

endpackage

//--- rtl/csr_op_unit.sv
// *********************************************************************
// CSR request decode
//   read and write strobes for the CSR file
//   read-modify-write data for csrrw, csrrs and csrrc
// *********************************************************************
`include "csr_cfg.svh"

module csr_op_unit (
    input  csr_pkg::csr_req_t     csr_req,
    input  logic [`CSR_XLEN-1:0]  old_val,
    output logic [11:0]           csr_idx,
    output logic                  rd_en,
    output logic                  wr_en,
    output logic [`CSR_XLEN-1:0]  wr_val
);
    import csr_pkg::*;

    logic set_clr;
    logic src_zero;

    assign csr_idx = csr_req.addr;

    // every valid access returns the old value to rd
    assign rd_en = csr_req.valid;

    // csrrs / csrrc with a zero source must not write
    assign set_clr  = (csr_req.op == CSR_RS) || (csr_req.op == CSR_RC);
    assign src_zero = (csr_req.src == '0);
    assign wr_en    = csr_req.valid && !(set_clr && src_zero);

    always_comb begin
        case (csr_req.op)
            CSR_RW: begin
                wr_val = csr_req.src;
            end
            CSR_RS: begin
                wr_val = old_val | csr_req.src;
            end
            CSR_RC: begin
                wr_val = old_val & ~csr_req.src;
            end
            default: begin
                // unused encoding writes back the old value
                wr_val = old_val;
            end
        endcase
    end

    // a write never happens without the matching read of the old value
    always_comb begin
        a_wr_needs_rd: assert final (!wr_en || rd_en);
    end

endmodule

//--- rtl/csr_file.sv
// *********************************************************************
// machine-mode CSR register file
//   mstatus, mie, mtvec, mscratch, mepc, mcause, mip, mcycle
//   trap entry and mret side effects on mstatus, mepc, mcause
//   machine timer interrupt qualification
// *********************************************************************
`include "csr_cfg.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  wr_mscrstch,
    input  logic [11:0]           csr_idx,
    input  logic                  rd_en,
    input  logic                  wr_en,
    input  logic [`CSR_XLEN-1:0]  wr_val,
    input  trap_pkg::trap_evt_t   trap_evt,
    input  logic                  tmr_pend,
    output logic [`CSR_XLEN-1:0]  rd_val,
    output logic [`CSR_XLEN-1:0]  mtvec,
    output logic [`CSR_XLEN-1:0]  mepc,
    output logic                  tmr_trap
);
    import csr_pkg::*;

    logic sel_mstatus, sel_mie, sel_mtvec, sel_mscratch;
    logic sel_mepc, sel_mcause, sel_mip, sel_mcycle;

    logic                                       mstatus_mie;
    logic                                       mstatus_mpie;
    logic [1:0]                                 mstatus_mpp;
    logic [1:0]                                 mstatus_fs;
    logic                                       mstatus_sd;
    logic [`CSR_XLEN-1:0]                       mstatus_val;
    logic                                       mie_mtie;
    logic                                       mip_mtip;
    logic [`CSR_XLEN-1:`CSR_MTVEC_ALIGN]        mtvec_base;
    logic [`CSR_XLEN-1:0]                       mscratch;
    logic [`CSR_XLEN-1:0]                       mcause;
    logic [`CSR_XLEN-1:0]                       mcycle;

    // address decode
    assign sel_mstatus  = (csr_idx == CSR_MSTATUS);
    assign sel_mie      = (csr_idx == CSR_MIE);
    assign sel_mtvec    = (csr_idx == CSR_MTVEC);
    assign sel_mscratch = (csr_idx == CSR_MSCRATCH);
    assign sel_mepc     = (csr_idx == CSR_MEPC);
    assign sel_mcause   = (csr_idx == CSR_MCAUSE);
    assign sel_mip      = (csr_idx == CSR_MIP);
    assign sel_mcycle   = (csr_idx == CSR_MCYCLE);

    // mstatus, trap entry and mret take priority over a CSR write
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= 2'b00;
            mstatus_fs   <= 2'b00;
        end else if (trap_evt.take) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= 2'b11;
        end else if (trap_evt.ret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= 2'b00;
        end else if (wr_en && sel_mstatus) begin
            mstatus_mie  <= wr_val[3];
            mstatus_mpie <= wr_val[7];
            mstatus_mpp  <= wr_val[12:11];
            mstatus_fs   <= wr_val[14:13];
        end
    end

    // xs is hardwired off, so only a dirty fs sets sd
    assign mstatus_sd = (mstatus_fs == 2'b11);

    always_comb begin
        mstatus_val              = '0;
        mstatus_val[`CSR_XLEN-1] = mstatus_sd;
        mstatus_val[14:13]       = mstatus_fs;
        mstatus_val[12:11]       = mstatus_mpp;
        mstatus_val[7]           = mstatus_mpie;
        mstatus_val[3]           = mstatus_mie;
    end

    // simple read/write registers
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mie_mtie   <= 1'b0;
            mtvec_base <= '0;
            mscratch   <= '0;
        end else begin
            if (wr_en && sel_mie) begin
                mie_mtie <= wr_val[7];
            end
            if (wr_en && sel_mtvec) begin
                mtvec_base <= wr_val[`CSR_XLEN-1:`CSR_MTVEC_ALIGN];
            end
            if (wr_en && sel_mscratch) begin
                mscratch <= wr_val;
            end
        end
    end

    // mepc and mcause are loaded by trap entry or by software
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mepc   <= '0;
            mcause <= '0;
        end else if (trap_evt.take) begin
            mepc   <= {trap_evt.epc[`CSR_XLEN-1:`CSR_MTVEC_ALIGN], {`CSR_MTVEC_ALIGN{1'b0}}};
            mcause <= trap_evt.cause;
        end else begin
            if (wr_en && sel_mepc) begin
                mepc <= {wr_val[`CSR_XLEN-1:`CSR_MTVEC_ALIGN], {`CSR_MTVEC_ALIGN{1'b0}}};
            end
            if (wr_en && sel_mcause) begin
                mcause <= wr_val;
            end
        end
    end

    // free-running cycle counter, a write reloads it
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mcycle <= '0;
        end else if (wr_en && sel_mcycle) begin
            mcycle <= wr_val;
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    // mtip is read-only and trails the timer by one edge
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mip_mtip <= 1'b0;
        end else begin
            mip_mtip <= tmr_pend;
        end
    end

    // direct mode only
    assign mtvec = {mtvec_base, {`CSR_MTVEC_ALIGN{1'b0}}};

    // commit pc qualification is applied in trap_ctrl
    assign tmr_trap = mip_mtip && mstatus_mie && mie_mtie;

    // unknown index selects nothing and reads zero
    assign rd_val = ({`CSR_XLEN{rd_en && sel_mstatus}}  & mstatus_val)
                  | ({`CSR_XLEN{rd_en && sel_mie}}      & {56'd0, mie_mtie, 7'd0})
                  | ({`CSR_XLEN{rd_en && sel_mtvec}}    & mtvec)
                  | ({`CSR_XLEN{rd_en && sel_mscratch}} & mscratch)
                  | ({`CSR_XLEN{rd_en && sel_mepc}}     & mepc)
                  | ({`CSR_XLEN{rd_en && sel_mcause}}   & mcause)
                  | ({`CSR_XLEN{rd_en && sel_mip}}      & {56'd0, mip_mtip, 7'd0})
                  | ({`CSR_XLEN{rd_en && sel_mcycle}}   & mcycle);

    a_take_ret_excl: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !(trap_evt.take && trap_evt.ret));

    // a taken timer trap needs MIE and closes it on the next edge
    a_tmr_trap_mie: assert property (@(posedge clk) disable iff (wr_mscrstch)
        (tmr_trap && trap_evt.take) |-> mstatus_mie ##1 !mstatus_mie);

endmodule

//--- rtl/trap_ctrl.sv
// *********************************************************************
// trap control
//   ranks timer trap, ecall and mret at commit
//   holds all events off while the pipeline stalls
//   forms the mcause value and the pc redirect
// *********************************************************************
`include "csr_cfg.svh"

module trap_ctrl (
    input  trap_pkg::commit_evt_t  commit,
    input  logic                   ex_stall,
    input  logic                   tmr_trap,
    input  logic [`CSR_XLEN-1:0]   mtvec,
    input  logic [`CSR_XLEN-1:0]   mepc,
    output trap_pkg::trap_evt_t    trap_evt,
    output trap_pkg::redirect_t    redirect
);
    import trap_pkg::*;

    logic tmr_go;
    logic ecall_go;
    logic mret_go;

    // no interrupt is taken on a bubble with a zero pc
    assign tmr_go   = tmr_trap && (commit.pc != '0) && !ex_stall;
    assign ecall_go = commit.ecall && !ex_stall && !tmr_go;
    assign mret_go  = commit.mret && !ex_stall && !tmr_go && !commit.ecall;

    assign trap_evt.take  = tmr_go || ecall_go;
    assign trap_evt.ret   = mret_go;
    assign trap_evt.cause = tmr_go ? CAUSE_M_TIMER : CAUSE_ECALL_M;
    assign trap_evt.epc   = commit.pc;

    // same-cycle redirect, mepc target only for mret
    assign redirect.valid  = trap_evt.take || trap_evt.ret;
    assign redirect.target = trap_evt.take ? mtvec : mepc;

    always_comb begin
        a_no_redirect_stall: assert final (!(ex_stall && redirect.valid));
    end

endmodule

//--- rtl/clint_timer.sv
// *********************************************************************
// core-local timer
//   mtime counter and mtimecmp compare register
//   Wishbone classic slave, single-cycle ack
//   registered machine timer pending flag
// *********************************************************************
`include "csr_cfg.svh"

module clint_timer (
    input  logic                       clk,
    input  logic                       wr_mscrstch,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`CSR_TMR_ADR_W-1:0]  wb_adr,
    input  logic [`CSR_XLEN-1:0]       wb_dat_w,
    output logic [`CSR_XLEN-1:0]       wb_dat_r,
    output logic                       wb_ack,
    output logic                       tmr_pend
);

    logic [`CSR_XLEN-1:0] mtime;
    logic [`CSR_XLEN-1:0] mtimecmp;
    logic                 wb_req;
    logic                 wb_wr;
    logic                 sel_cmp;
    logic                 sel_time;

    // master still holds stb during the ack cycle
    assign wb_req   = wb_cyc && wb_stb && !wb_ack;
    assign wb_wr    = wb_req && wb_we;
    assign sel_cmp  = (wb_adr == `CSR_TMR_CMP_OFS);
    assign sel_time = (wb_adr == `CSR_TMR_TIME_OFS);

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // read data is launched with the ack
    always_ff @(posedge clk) begin
        if (wb_req && !wb_we) begin
            wb_dat_r <= ({`CSR_XLEN{sel_cmp}} & mtimecmp)
                      | ({`CSR_XLEN{sel_time}} & mtime);
        end
    end

    // a bus write to mtime wins over the increment
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtime <= '0;
        end else if (wb_wr && sel_time) begin
            mtime <= wb_dat_w;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps the compare quiet out of reset
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtimecmp <= '1;
        end else if (wb_wr && sel_cmp) begin
            mtimecmp <= wb_dat_w;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            tmr_pend <= 1'b0;
        end else begin
            tmr_pend <= (mtime >= mtimecmp);
        end
    end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (wr_mscrstch)
        wb_ack |=> !wb_ack);

endmodule

//--- rtl/csr_unit_top.sv
// *********************************************************************
// machine CSR subsystem top level
//   CSR request decode, CSR register file
//   trap control with pc redirect
//   CLINT timer on a Wishbone classic slave port
// *********************************************************************
`include "csr_cfg.svh"

module csr_unit_top (
    input  logic                       clk,
    input  logic                       wr_mscrstch,
    input  csr_pkg::csr_req_t          csr_req,
    input  trap_pkg::commit_evt_t      commit,
    input  logic                       ex_stall,
    output logic [`CSR_XLEN-1:0]       csr_rdata,
    output trap_pkg::redirect_t        redirect,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [`CSR_TMR_ADR_W-1:0]  wb_adr,
    input  logic [`CSR_XLEN-1:0]       wb_dat_w,
    output logic [`CSR_XLEN-1:0]       wb_dat_r,
    output logic                       wb_ack
);
    import trap_pkg::*;

    logic [11:0]          csr_idx;
    logic                 rd_en;
    logic                 wr_en;
    logic [`CSR_XLEN-1:0] wr_val;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    logic                 tmr_trap;
    logic                 tmr_pend;
    trap_evt_t            trap_evt;

    // csr_rdata is the old value, also fed back for read-modify-write
    csr_op_unit u_csr_op_unit (
        .csr_req (csr_req),
        .old_val (csr_rdata),
        .csr_idx (csr_idx),
        .rd_en   (rd_en),
        .wr_en   (wr_en),
        .wr_val  (wr_val)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .csr_idx     (csr_idx),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .wr_val      (wr_val),
        .trap_evt    (trap_evt),
        .tmr_pend    (tmr_pend),
        .rd_val      (csr_rdata),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .tmr_trap    (tmr_trap)
    );

    trap_ctrl u_trap_ctrl (
        .commit   (commit),
        .ex_stall (ex_stall),
        .tmr_trap (tmr_trap),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .trap_evt (trap_evt),
        .redirect (redirect)
    );

    clint_timer u_clint_timer (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .tmr_pend    (tmr_pend)
    );

endmodule

//--- testbench/tb_csr_unit.sv
// *********************************************************************
// testbench for the machine CSR subsystem
//   clock, reset and falling-edge stimulus
//   CSR access, commit event and Wishbone tasks
//   concurrent checks against testbench-held expected values
//   per-test report and closing counts
// *********************************************************************
`include "csr_cfg.svh"

module tb_csr_unit;
    import csr_pkg::*;
    import trap_pkg::*;

    logic                      clk;
    logic                      wr_mscrstch;
    csr_req_t                  csr_req;
    commit_evt_t               commit;
    logic                      ex_stall;
    logic [`CSR_XLEN-1:0]      csr_rdata;
    redirect_t                 redirect;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`CSR_TMR_ADR_W-1:0] wb_adr;
    logic [`CSR_XLEN-1:0]      wb_dat_w;
    logic [`CSR_XLEN-1:0]      wb_dat_r;
    logic                      wb_ack;

    // expected values, set together with the stimulus
    logic                 exp_rd_chk;
    logic [`CSR_XLEN-1:0] exp_rdata;
    logic                 exp_redir_chk;
    logic                 exp_redir_valid;
    logic [`CSR_XLEN-1:0] exp_target;
    logic                 exp_wb_chk;
    logic [`CSR_XLEN-1:0] exp_wb_dat;

    logic [`CSR_XLEN-1:0] m_scratch;
    logic [`CSR_XLEN-1:0] m_mtvec;
    logic [`CSR_XLEN-1:0] got;
    logic [`CSR_XLEN-1:0] d1;
    logic [`CSR_XLEN-1:0] d2;
    logic                 found;
    integer               seed;
    int                   n_checks;
    int                   n_errors;
    int                   n_tests;
    int                   i;

    csr_unit_top u_csr_unit_top (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .csr_req     (csr_req),
        .commit      (commit),
        .ex_stall    (ex_stall),
        .csr_rdata   (csr_rdata),
        .redirect    (redirect),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] act,
                                   input logic [63:0] exp);
        n_errors = n_errors + 1;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, act, exp);
    endtask

    a_rdata: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !exp_rd_chk || (csr_rdata == exp_rdata))
        begin if (exp_rd_chk) n_checks++; end
        else report_mismatch("csr_rdata", $sampled(csr_rdata), exp_rdata);

    a_redir_valid: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !exp_redir_chk || (redirect.valid == exp_redir_valid))
        begin if (exp_redir_chk) n_checks++; end
        else report_mismatch("redirect.valid", 64'($sampled(redirect.valid)),
                             64'(exp_redir_valid));

    a_redir_target: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !(exp_redir_chk && exp_redir_valid) || (redirect.target == exp_target))
        begin if (exp_redir_chk && exp_redir_valid) n_checks++; end
        else report_mismatch("redirect.target", $sampled(redirect.target), exp_target);

    a_wb_rdata: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !(exp_wb_chk && wb_ack) || (wb_dat_r == exp_wb_dat))
        begin if (exp_wb_chk && wb_ack) n_checks++; end
        else report_mismatch("wb_dat_r", $sampled(wb_dat_r), exp_wb_dat);

    // ack is a single-cycle pulse
    a_ack_pulse: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !(wb_ack && $past(wb_ack)))
        else begin
            n_errors = n_errors + 1;
            $display("wb_ack stayed high for two cycles at t=%0t", $time);
        end

    // bit positions of the mstatus fields kept by the design
    function automatic logic [63:0] mstatus_word(input logic mie, input logic mpie,
                                                 input logic [1:0] mpp);
        logic [63:0] w;
        w        = '0;
        w[3]     = mie;
        w[7]     = mpie;
        w[12:11] = mpp;
        return w;
    endfunction

    task automatic set_idle();
        csr_req       = '0;
        commit        = '0;
        ex_stall      = 1'b0;
        exp_rd_chk    = 1'b0;
        exp_redir_chk = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            set_idle();
        end
    endtask

    // one CSR access, rdata captured after the inputs settle
    task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                              input logic [63:0] src, input logic chk,
                              input logic [63:0] exp, output logic [63:0] rdat);
        @(negedge clk);
        set_idle();
        csr_req.valid = 1'b1;
        csr_req.op    = op;
        csr_req.addr  = addr;
        csr_req.src   = src;
        exp_rd_chk    = chk;
        exp_rdata     = exp;
        #1;
        rdat = csr_rdata;
    endtask

    task automatic csr_check(input csr_op_e op, input logic [11:0] addr,
                             input logic [63:0] src, input logic [63:0] exp);
        csr_access(op, addr, src, 1'b1, exp, got);
    endtask

    task automatic commit_cycle(input logic ecall, input logic mret, input logic [63:0] pc,
                                input logic stall, input logic valid,
                                input logic [63:0] target);
        @(negedge clk);
        set_idle();
        commit.ecall    = ecall;
        commit.mret     = mret;
        commit.pc       = pc;
        ex_stall        = stall;
        exp_redir_chk   = 1'b1;
        exp_redir_valid = valid;
        exp_target      = target;
    endtask

    task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [63:0] wdat,
                           input logic chk, input logic [63:0] exp,
                           output logic [63:0] rdat);
        int wait_cnt;
        @(negedge clk);
        set_idle();
        wb_cyc     = 1'b1;
        wb_stb     = 1'b1;
        wb_we      = we;
        wb_adr     = adr;
        wb_dat_w   = wdat;
        exp_wb_chk = chk && !we;
        exp_wb_dat = exp;
        rdat       = '0;
        wait_cnt   = 0;
        while (!wb_ack && wait_cnt < 20) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (wb_ack) begin
            rdat = wb_dat_r;
        end else begin
            n_errors = n_errors + 1;
            $display("no wb_ack within 20 cycles at t=%0t", $time);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // keep the data check armed over the ack sample edge
        @(negedge clk);
        exp_wb_chk = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [63:0] wdat);
        wb_xfer(1'b1, adr, wdat, 1'b0, '0, got);
    endtask

    task automatic wb_read(input logic [3:0] adr, input logic chk, input logic [63:0] exp,
                           output logic [63:0] rdat);
        wb_xfer(1'b0, adr, '0, chk, exp, rdat);
    endtask

    task automatic test_done(input string name);
        n_tests = n_tests + 1;
        $display("test %0d %s finished, errors so far %0d", n_tests, name, n_errors);
    endtask

    initial begin
        seed            = 32'h3f41;
        n_checks        = 0;
        n_errors        = 0;
        n_tests         = 0;
        wr_mscrstch     = 1'b1;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = '0;
        wb_dat_w        = '0;
        exp_rdata       = '0;
        exp_redir_valid = 1'b0;
        exp_target      = '0;
        exp_wb_chk      = 1'b0;
        exp_wb_dat      = '0;
        set_idle();
        repeat (8) @(negedge clk);
        wr_mscrstch = 1'b0;

        d1 = {$random(seed), $random(seed)};
        d2 = {$random(seed), $random(seed)};
        csr_check(CSR_RW, CSR_MSCRATCH, d1, 64'h0);
        csr_check(CSR_RW, CSR_MSCRATCH, d2, d1);
        csr_check(CSR_RS, CSR_MSCRATCH, 64'h0, d2);
        m_scratch = d2;
        test_done("mscratch swap");

        d1 = {$random(seed), $random(seed)};
        d2 = {$random(seed), $random(seed)};
        csr_check(CSR_RS, CSR_MSCRATCH, d1, m_scratch);
        m_scratch = m_scratch | d1;
        csr_check(CSR_RC, CSR_MSCRATCH, d2, m_scratch);
        m_scratch = m_scratch & ~d2;
        csr_check(CSR_RS, CSR_MSCRATCH, 64'h0, m_scratch);
        csr_check(CSR_RS, CSR_MSCRATCH, 64'h0, m_scratch);
        csr_check(CSR_RW, CSR_MIE, '1, 64'h0);
        csr_check(CSR_RS, CSR_MIE, 64'h0, 64'h80);
        csr_check(CSR_RC, CSR_MIE, 64'h80, 64'h80);
        csr_check(CSR_RS, CSR_MIE, 64'h0, 64'h0);
        csr_check(CSR_RW, 12'h7C0, d1, 64'h0);
        csr_check(CSR_RS, 12'h7C0, 64'h0, 64'h0);
        test_done("set, clear and unknown index");

        m_mtvec = 64'h8000_1000;
        csr_check(CSR_RW, CSR_MTVEC, 64'h8000_1003, 64'h0);
        csr_check(CSR_RS, CSR_MSTATUS, 64'h8, 64'h0);
        commit_cycle(1'b1, 1'b0, 64'h8000_2006, 1'b0, 1'b1, m_mtvec);
        csr_check(CSR_RS, CSR_MEPC, 64'h0, 64'h8000_2004);
        csr_check(CSR_RS, CSR_MCAUSE, 64'h0, 64'd11);
        csr_check(CSR_RS, CSR_MSTATUS, 64'h0, mstatus_word(1'b0, 1'b1, 2'b11));
        test_done("ecall entry");

        commit_cycle(1'b0, 1'b1, 64'h8000_2100, 1'b0, 1'b1, 64'h8000_2004);
        csr_check(CSR_RS, CSR_MSTATUS, 64'h0, mstatus_word(1'b1, 1'b1, 2'b00));
        commit_cycle(1'b1, 1'b0, 64'h8000_2200, 1'b1, 1'b0, '0);
        commit_cycle(1'b0, 1'b1, 64'h8000_2200, 1'b1, 1'b0, '0);
        csr_check(CSR_RS, CSR_MSTATUS, 64'h0, mstatus_word(1'b1, 1'b1, 2'b00));
        csr_check(CSR_RS, CSR_MEPC, 64'h0, 64'h8000_2004);
        test_done("mret and stall");

        wb_read(`CSR_TMR_TIME_OFS, 1'b0, '0, d1);
        wb_write(`CSR_TMR_CMP_OFS, d1 + 64'd20);
        wb_read(`CSR_TMR_CMP_OFS, 1'b1, d1 + 64'd20, d2);
        csr_check(CSR_RS, CSR_MIE, 64'h80, 64'h0);
        csr_check(CSR_RS, CSR_MSTATUS, 64'h8, mstatus_word(1'b1, 1'b1, 2'b00));
        // poll mip with a zero pc so no trap is taken yet
        found = 1'b0;
        i     = 0;
        while (!found && i < 100) begin
            csr_access(CSR_RS, CSR_MIP, 64'h0, 1'b0, '0, got);
            found = got[7];
            i++;
        end
        if (found) begin
            csr_check(CSR_RS, CSR_MIP, 64'h0, 64'h80);
        end else begin
            n_errors = n_errors + 1;
            $display("mip.MTIP not set within 100 cycles");
        end
        // the first commit with a nonzero pc takes the timer trap
        commit_cycle(1'b0, 1'b0, 64'h8000_3000, 1'b0, 1'b1, m_mtvec);
        // MIE is now clear, so no second redirect
        repeat (4) begin
            commit_cycle(1'b0, 1'b0, 64'h8000_3000, 1'b0, 1'b0, '0);
        end
        csr_check(CSR_RS, CSR_MCAUSE, 64'h0, {1'b1, 63'd7});
        csr_check(CSR_RS, CSR_MSTATUS, 64'h0, mstatus_word(1'b0, 1'b1, 2'b11));
        test_done("timer interrupt");

        csr_access(CSR_RS, CSR_MCYCLE, 64'h0, 1'b0, '0, d1);
        idle_cycles(4);
        csr_check(CSR_RS, CSR_MCYCLE, 64'h0, d1 + 64'd5);
        d2 = {$random(seed), $random(seed)};
        csr_access(CSR_RW, CSR_MCYCLE, d2, 1'b0, '0, got);
        idle_cycles(3);
        csr_check(CSR_RS, CSR_MCYCLE, 64'h0, d2 + 64'd3);
        test_done("mcycle count");

        idle_cycles(2);
        $display("tests %0d, checks passed %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/trap_pkg.sv
rtl/csr_op_unit.sv
rtl/csr_file.sv
rtl/trap_ctrl.sv
rtl/clint_timer.sv
rtl/csr_unit_top.sv
testbench/tb_csr_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_csr_unit
RTL_TOP   ?= csr_unit_top
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the simulation passes only if the pass line shows up in its output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
